// File: rob_pkg.sv
package rob_pkg;

  localparam int DISP_SIZE      = 2;
  localparam int CMT_ENTRY_SIZE = 8;
  localparam int CMT_ENTRY_W    = 3;
  localparam int CMT_ID_W       = CMT_ENTRY_W + 1;  // Extra wrap bit
  localparam int SLOT_W         = 1;
  localparam int VADDR_W        = 32;
  localparam int RD_W           = 6;

  localparam logic [VADDR_W-1:0] TRAP_VADDR = '0;

  typedef enum logic [2:0] {
    NONE          = 3'd0,
    INST_MISALIGN = 3'd1,
    ILLEGAL_INST  = 3'd2,
    ECALL         = 3'd3,
    LOAD_FAULT    = 3'd4
  } except_t;

  typedef struct packed {
    logic            valid;
    logic            rd_valid;
    logic [RD_W-1:0] rd_tag;
  } disp_slot_t;

  typedef struct packed {
    logic [VADDR_W-1:0]             pc;  // Word aligned
    disp_slot_t [DISP_SIZE-1:0]     slot;
  } disp_grp_t;

  typedef struct packed {
    logic                valid;
    logic [CMT_ID_W-1:0] cmt_id;
    logic [SLOT_W-1:0]   slot;
    logic                except_valid;
    except_t             except_type;
    logic                br_taken;
    logic [VADDR_W-1:0]  br_target;
  } exec_op_t;

  typedef struct packed {
    logic                valid;
    logic [CMT_ID_W-1:0] cmt_id;
    logic [SLOT_W-1:0]   slot;
    logic                except_valid;
    except_t             except_type;
    logic                br_taken;
    logic [VADDR_W-1:0]  br_target;
  } done_rpt_t;

  typedef struct packed {
    logic                          commit;
    logic [CMT_ID_W-1:0]           cmt_id;
    logic [DISP_SIZE-1:0]          grp_id;
    logic                          all_dead;
    logic [DISP_SIZE-1:0]          dead_id;
    logic                          upd_pc_valid;
    logic [VADDR_W-1:0]            upd_pc_vaddr;
    logic [DISP_SIZE-1:0]          except_valid;
    except_t                       except_type;
    logic [VADDR_W-1:0]            epc;
    logic [DISP_SIZE-1:0]          rd_valid;
    logic [DISP_SIZE-1:0][RD_W-1:0] rd_tag;
  } commit_t;

endpackage

// File: rob_entry.sv
`timescale 1ns/1ps

module rob_entry #(
  parameter int ENTRY_IDX = 0
) (
  input  logic                                             i_clk,
  input  logic                                             i_reset_n,
  input  logic                                             i_load_valid,
  input  rob_pkg::disp_grp_t                               i_load_grp,
  input  rob_pkg::done_rpt_t                               i_done_rpt,
  input  logic                                             i_kill,
  input  logic                                             i_commit_finish,
  output logic                                             o_valid,
  output logic                                             o_dead,
  output rob_pkg::disp_grp_t                               o_grp,
  output logic [rob_pkg::DISP_SIZE-1:0]                    o_done_grp_id,
  output logic [rob_pkg::DISP_SIZE-1:0]                    o_except_valid,
  output rob_pkg::except_t [rob_pkg::DISP_SIZE-1:0]        o_except_type,
  output logic [rob_pkg::DISP_SIZE-1:0]                    o_br_taken,
  output logic [rob_pkg::DISP_SIZE-1:0][rob_pkg::VADDR_W-1:0] o_br_target,
  output logic                                             o_all_done
);

  localparam logic [rob_pkg::CMT_ENTRY_W-1:0] IDX = ENTRY_IDX[rob_pkg::CMT_ENTRY_W-1:0];

  logic                                                r_valid;
  logic                                                r_dead;
  logic [rob_pkg::DISP_SIZE-1:0]                       r_done;
  logic [rob_pkg::DISP_SIZE-1:0]                       r_except_valid;
  logic [rob_pkg::DISP_SIZE-1:0]                       r_br_taken;
  rob_pkg::disp_grp_t                                  r_grp;
  rob_pkg::except_t [rob_pkg::DISP_SIZE-1:0]           r_except_type;
  logic [rob_pkg::DISP_SIZE-1:0][rob_pkg::VADDR_W-1:0] r_br_target;
  logic [rob_pkg::DISP_SIZE-1:0]                       w_slot_valid;
  logic                                                w_hit;

  for (genvar d = 0; d < rob_pkg::DISP_SIZE; d++) begin : g_slot
    assign w_slot_valid[d] = r_grp.slot[d].valid;
  end

  // Report for this entry, lower id bits only
  assign w_hit = r_valid & i_done_rpt.valid & (i_done_rpt.cmt_id[rob_pkg::CMT_ENTRY_W-1:0] == IDX);

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid        <= 1'b0;
      r_dead         <= 1'b0;
      r_done         <= '0;
      r_except_valid <= '0;
      r_br_taken     <= '0;
    end else if (i_load_valid) begin
      r_valid        <= 1'b1;
      r_dead         <= i_kill;  // Arrives during a flush, drained by the kill walk
      r_done         <= '0;
      r_except_valid <= '0;
      r_br_taken     <= '0;
    end else if (i_commit_finish) begin
      r_valid <= 1'b0;
      r_dead  <= 1'b0;
    end else begin
      if (i_kill & r_valid) begin
        r_dead <= 1'b1;
      end
      if (w_hit) begin
        r_done[i_done_rpt.slot]         <= 1'b1;
        r_except_valid[i_done_rpt.slot] <= i_done_rpt.except_valid;
        r_br_taken[i_done_rpt.slot]     <= i_done_rpt.br_taken;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_load_valid) begin
      r_grp <= i_load_grp;
    end
    if (w_hit) begin
      r_except_type[i_done_rpt.slot] <= i_done_rpt.except_type;
      r_br_target[i_done_rpt.slot]   <= i_done_rpt.br_target;
    end
  end

  assign o_valid        = r_valid;
  assign o_dead         = r_dead;
  assign o_grp          = r_grp;
  assign o_done_grp_id  = r_done & w_slot_valid;
  assign o_except_valid = r_except_valid;
  assign o_except_type  = r_except_type;
  assign o_br_taken     = r_br_taken;
  assign o_br_target    = r_br_target;
  assign o_all_done     = r_valid & (&(r_done | ~w_slot_valid));

endmodule

// File: rob_credit_counter.sv
`timescale 1ns/1ps

module rob_credit_counter #(
  parameter int MAX_CREDITS = 8
) (
  input  logic i_clk,
  input  logic i_reset_n,
  input  logic i_disp,
  input  logic i_commit,
  output logic o_disp_ok
);

  localparam int CNT_W = $clog2(MAX_CREDITS + 1);
  localparam logic [CNT_W-1:0] FULL = CNT_W'(MAX_CREDITS);

  logic [CNT_W-1:0] r_credits;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_credits <= FULL;
    end else begin
      case ({i_disp, i_commit})
        2'b10: begin
          if (r_credits != '0) begin
            r_credits <= r_credits - 1'b1;
          end
        end
        2'b01: begin
          if (r_credits != FULL) begin
            r_credits <= r_credits + 1'b1;
          end
        end
        default: ;  // Both or neither, no change
      endcase
    end
  end

  assign o_disp_ok = (r_credits != '0);

endmodule

// File: done_arbiter.sv
`timescale 1ns/1ps

module done_arbiter #(
  parameter type T       = logic,
  parameter int  NUM_REQ = 2
) (
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  logic [NUM_REQ-1:0] i_req,
  input  T                   i_payload [NUM_REQ],
  output logic [NUM_REQ-1:0] o_grant,
  output T                   o_payload,
  output logic               o_valid
);

  localparam int PTR_W = (NUM_REQ > 1) ? $clog2(NUM_REQ) : 1;

  logic [PTR_W-1:0] r_last;
  logic [PTR_W-1:0] w_sel;

  // Search starts just past the last winner
  always_comb begin
    int   idx;
    logic found;
    idx     = 0;
    found   = 1'b0;
    o_grant = '0;
    w_sel   = r_last;
    for (int off = 1; off <= NUM_REQ; off++) begin
      idx = (int'(r_last) + off) % NUM_REQ;
      if (!found && i_req[idx]) begin
        found        = 1'b1;
        o_grant[idx] = 1'b1;
        w_sel        = idx[PTR_W-1:0];
      end
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_last <= PTR_W'(NUM_REQ - 1);  // Requester 0 first
    end else if (o_valid) begin
      r_last <= w_sel;
    end
  end

  assign o_valid   = |i_req;
  assign o_payload = i_payload[w_sel];

endmodule

// File: exec_pipe.sv
`timescale 1ns/1ps

module exec_pipe #(
  parameter int LATENCY = 1
) (
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  rob_pkg::exec_op_t  i_issue,
  output logic               o_issue_ready,
  output logic               o_req,
  output rob_pkg::done_rpt_t o_rpt,
  input  logic               i_grant
);

  rob_pkg::exec_op_t  r_op [LATENCY];  // Last stage is the hold register
  logic [LATENCY-1:0] r_vld;
  logic               w_stall;

  assign w_stall       = r_vld[LATENCY-1] & ~i_grant;
  assign o_issue_ready = ~w_stall;
  assign o_req         = r_vld[LATENCY-1];

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_vld <= '0;
    end else if (!w_stall) begin
      r_vld[0] <= i_issue.valid;
      for (int k = 1; k < LATENCY; k++) begin
        r_vld[k] <= r_vld[k-1];
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (!w_stall) begin
      r_op[0] <= i_issue;
      for (int k = 1; k < LATENCY; k++) begin
        r_op[k] <= r_op[k-1];
      end
    end
  end

  always_comb begin
    o_rpt.valid        = r_vld[LATENCY-1];
    o_rpt.cmt_id       = r_op[LATENCY-1].cmt_id;
    o_rpt.slot         = r_op[LATENCY-1].slot;
    o_rpt.except_valid = r_op[LATENCY-1].except_valid;
    o_rpt.except_type  = r_op[LATENCY-1].except_type;
    o_rpt.br_taken     = r_op[LATENCY-1].br_taken & ~r_op[LATENCY-1].except_valid;
    o_rpt.br_target    = r_op[LATENCY-1].br_target;
  end

endmodule

// File: rob_commit_sel.sv
`timescale 1ns/1ps

module rob_commit_sel (
  input  rob_pkg::disp_grp_t                                i_grp,
  input  logic [rob_pkg::DISP_SIZE-1:0]                     i_except_valid,
  input  rob_pkg::except_t [rob_pkg::DISP_SIZE-1:0]         i_except_type,
  input  logic [rob_pkg::DISP_SIZE-1:0]                     i_br_taken,
  input  logic [rob_pkg::DISP_SIZE-1:0][rob_pkg::VADDR_W-1:0] i_br_target,
  output logic                                              o_upd_pc_valid,
  output logic [rob_pkg::VADDR_W-1:0]                       o_upd_pc_vaddr,
  output logic [rob_pkg::DISP_SIZE-1:0]                     o_except_valid,
  output rob_pkg::except_t                                  o_except_type,
  output logic [rob_pkg::VADDR_W-1:0]                       o_epc,
  output logic [rob_pkg::DISP_SIZE-1:0]                     o_dead_id
);

  localparam int PAD_W = rob_pkg::VADDR_W - rob_pkg::SLOT_W - 2;

  // Lowest redirecting slot wins, exception over branch
  always_comb begin
    logic found;
    found          = 1'b0;
    o_upd_pc_valid = 1'b0;
    o_upd_pc_vaddr = '0;
    o_except_valid = '0;
    o_except_type  = rob_pkg::NONE;
    o_epc          = '0;
    o_dead_id      = '0;
    for (int d = 0; d < rob_pkg::DISP_SIZE; d++) begin
      if (found) begin
        o_dead_id[d] = i_grp.slot[d].valid;  // Younger than the redirect
      end else if (i_grp.slot[d].valid && (i_except_valid[d] || i_br_taken[d])) begin
        found          = 1'b1;
        o_upd_pc_valid = 1'b1;
        if (i_except_valid[d]) begin
          o_except_valid[d] = 1'b1;
          o_except_type     = i_except_type[d];
          o_epc             = i_grp.pc + {{PAD_W{1'b0}}, d[rob_pkg::SLOT_W-1:0], 2'b00};
          o_upd_pc_vaddr    = rob_pkg::TRAP_VADDR;
        end else begin
          o_upd_pc_vaddr = i_br_target[d];
        end
      end
    end
  end

endmodule

// File: rob.sv
`timescale 1ns/1ps

module rob (
  input  logic                          i_clk,
  input  logic                          i_reset_n,
  input  logic                          i_disp_valid,
  input  rob_pkg::disp_grp_t            i_disp_grp,
  input  logic                          i_done_valid,
  input  rob_pkg::done_rpt_t            i_done_rpt,
  output logic [rob_pkg::CMT_ID_W-1:0]  o_new_cmt_id,
  output rob_pkg::commit_t              o_commit
);

  localparam int N = rob_pkg::CMT_ENTRY_SIZE;
  localparam int D = rob_pkg::DISP_SIZE;

  logic [N-1:0]                                w_valid;
  logic [N-1:0]                                w_dead;
  logic [N-1:0]                                w_all_done;
  logic [N-1:0]                                w_load;
  logic [N-1:0]                                w_finish;
  rob_pkg::disp_grp_t                          w_grp [N];
  logic [D-1:0]                                w_done_grp_id [N];
  logic [D-1:0]                                w_except_valid [N];
  rob_pkg::except_t [D-1:0]                    w_except_type [N];
  logic [D-1:0]                                w_br_taken [N];
  logic [D-1:0][rob_pkg::VADDR_W-1:0]          w_br_target [N];
  rob_pkg::done_rpt_t                          w_done_rpt;

  logic [rob_pkg::CMT_ID_W-1:0]    r_in_id;
  logic [rob_pkg::CMT_ID_W-1:0]    r_out_id;
  logic [rob_pkg::CMT_ID_W-1:0]    w_out_next;
  logic [rob_pkg::CMT_ENTRY_W-1:0] w_in_entry;
  logic [rob_pkg::CMT_ENTRY_W-1:0] w_head;
  logic                            r_killing;
  logic                            w_kill_now;
  logic                            w_commit;
  logic                            w_flush;
  rob_pkg::disp_grp_t              w_head_grp;
  logic [D-1:0]                    w_head_vmask;

  logic                            w_sel_upd;
  logic [rob_pkg::VADDR_W-1:0]     w_sel_vaddr;
  logic [D-1:0]                    w_sel_exc;
  rob_pkg::except_t                w_sel_type;
  logic [rob_pkg::VADDR_W-1:0]     w_sel_epc;
  logic [D-1:0]                    w_sel_dead;

  assign w_in_entry = r_in_id[rob_pkg::CMT_ENTRY_W-1:0];
  assign w_head     = r_out_id[rob_pkg::CMT_ENTRY_W-1:0];
  assign w_out_next = r_out_id + 1'b1;

  always_comb begin
    w_done_rpt       = i_done_rpt;
    w_done_rpt.valid = i_done_valid & i_done_rpt.valid;  // Only the granted report
  end

  for (genvar c = 0; c < N; c++) begin : g_entry
    assign w_load[c]   = i_disp_valid & (w_in_entry == c[rob_pkg::CMT_ENTRY_W-1:0]);
    assign w_finish[c] = w_commit & (w_head == c[rob_pkg::CMT_ENTRY_W-1:0]);

    rob_entry #(.ENTRY_IDX(c)) u_entry (
      .i_clk          (i_clk),
      .i_reset_n      (i_reset_n),
      .i_load_valid   (w_load[c]),
      .i_load_grp     (i_disp_grp),
      .i_done_rpt     (w_done_rpt),
      .i_kill         (w_flush),
      .i_commit_finish(w_finish[c]),
      .o_valid        (w_valid[c]),
      .o_dead         (w_dead[c]),
      .o_grp          (w_grp[c]),
      .o_done_grp_id  (w_done_grp_id[c]),
      .o_except_valid (w_except_valid[c]),
      .o_except_type  (w_except_type[c]),
      .o_br_taken     (w_br_taken[c]),
      .o_br_target    (w_br_target[c]),
      .o_all_done     (w_all_done[c])
    );
  end

  assign w_head_grp = w_grp[w_head];
  for (genvar d = 0; d < D; d++) begin : g_vmask
    assign w_head_vmask[d] = w_head_grp.slot[d].valid;
  end

  rob_commit_sel u_commit_sel (
    .i_grp         (w_head_grp),
    .i_except_valid(w_except_valid[w_head]),
    .i_except_type (w_except_type[w_head]),
    .i_br_taken    (w_br_taken[w_head]),
    .i_br_target   (w_br_target[w_head]),
    .o_upd_pc_valid(w_sel_upd),
    .o_upd_pc_vaddr(w_sel_vaddr),
    .o_except_valid(w_sel_exc),
    .o_except_type (w_sel_type),
    .o_epc         (w_sel_epc),
    .o_dead_id     (w_sel_dead)
  );

  assign w_kill_now = r_killing & w_valid[w_head] & w_dead[w_head];
  assign w_commit   = w_all_done[w_head] | w_kill_now;
  assign w_flush    = w_commit & w_sel_upd & ~w_dead[w_head];

  always_comb begin
    o_commit              = '0;
    o_commit.commit       = w_commit;
    o_commit.cmt_id       = r_out_id;
    o_commit.all_dead     = w_dead[w_head];
    o_commit.grp_id       = w_dead[w_head] ? w_head_vmask : w_done_grp_id[w_head];
    o_commit.dead_id      = w_dead[w_head] ? w_head_vmask : w_sel_dead;
    o_commit.upd_pc_valid = w_sel_upd & ~w_dead[w_head];
    o_commit.upd_pc_vaddr = w_sel_vaddr;
    o_commit.except_valid = w_sel_exc & {D{~w_dead[w_head]}};
    o_commit.except_type  = w_sel_type;
    o_commit.epc          = w_sel_epc;
    for (int d = 0; d < D; d++) begin
      o_commit.rd_valid[d] = w_head_grp.slot[d].valid & w_head_grp.slot[d].rd_valid;
      o_commit.rd_tag[d]   = w_head_grp.slot[d].rd_tag;
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_in_id   <= '0;
      r_out_id  <= '0;
      r_killing <= 1'b0;
    end else begin
      if (i_disp_valid) begin
        r_in_id <= r_in_id + 1'b1;
      end
      if (w_commit) begin
        r_out_id <= w_out_next;
      end
      // Younger groups exist, including one dispatched this cycle
      if (w_flush & ((r_in_id != w_out_next) | i_disp_valid)) begin
        r_killing <= 1'b1;
      end else if (r_killing & ~w_kill_now) begin
        r_killing <= 1'b0;
      end
    end
  end

  assign o_new_cmt_id = r_in_id;

endmodule

// File: rob_subsys_top.sv
`timescale 1ns/1ps

module rob_subsys_top #(
  parameter int ALU_LATENCY = 1,
  parameter int BR_LATENCY  = 2
) (
  input  logic                         i_clk,
  input  logic                         i_reset_n,
  input  logic                         i_disp_valid,
  input  rob_pkg::disp_grp_t           i_disp_grp,
  output logic                         o_disp_ok,
  output logic [rob_pkg::CMT_ID_W-1:0] o_new_cmt_id,
  input  rob_pkg::exec_op_t            i_issue_alu,
  input  rob_pkg::exec_op_t            i_issue_br,
  output logic                         o_issue_alu_ready,
  output logic                         o_issue_br_ready,
  output rob_pkg::commit_t             o_commit
);

  localparam int NUM_PIPES = 2;  // 0 ALU, 1 BR

  logic [NUM_PIPES-1:0] w_req;
  logic [NUM_PIPES-1:0] w_grant;
  rob_pkg::done_rpt_t   w_rpt [NUM_PIPES];
  rob_pkg::done_rpt_t   w_done_rpt;
  logic                 w_done_valid;

  rob u_rob (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_disp_valid(i_disp_valid),
    .i_disp_grp  (i_disp_grp),
    .i_done_valid(w_done_valid),
    .i_done_rpt  (w_done_rpt),
    .o_new_cmt_id(o_new_cmt_id),
    .o_commit    (o_commit)
  );

  rob_credit_counter #(.MAX_CREDITS(rob_pkg::CMT_ENTRY_SIZE)) u_credit (
    .i_clk    (i_clk),
    .i_reset_n(i_reset_n),
    .i_disp   (i_disp_valid),
    .i_commit (o_commit.commit),
    .o_disp_ok(o_disp_ok)
  );

  exec_pipe #(.LATENCY(ALU_LATENCY)) u_alu_pipe (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_issue      (i_issue_alu),
    .o_issue_ready(o_issue_alu_ready),
    .o_req        (w_req[0]),
    .o_rpt        (w_rpt[0]),
    .i_grant      (w_grant[0])
  );

  exec_pipe #(.LATENCY(BR_LATENCY)) u_br_pipe (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_issue      (i_issue_br),
    .o_issue_ready(o_issue_br_ready),
    .o_req        (w_req[1]),
    .o_rpt        (w_rpt[1]),
    .i_grant      (w_grant[1])
  );

  done_arbiter #(.T(rob_pkg::done_rpt_t), .NUM_REQ(NUM_PIPES)) u_done_arb (
    .i_clk    (i_clk),
    .i_reset_n(i_reset_n),
    .i_req    (w_req),
    .i_payload(w_rpt),
    .o_grant  (w_grant),
    .o_payload(w_done_rpt),
    .o_valid  (w_done_valid)
  );

endmodule

// File: tb_rob.sv
`timescale 1ns/1ps

module tb_rob;

  localparam int          TIMEOUT    = 200;
  localparam logic [31:0] TRAP_VADDR = 32'h0;

  logic                         i_clk;
  logic                         i_reset_n;
  logic                         i_disp_valid;
  rob_pkg::disp_grp_t           i_disp_grp;
  rob_pkg::exec_op_t            i_issue_alu;
  rob_pkg::exec_op_t            i_issue_br;
  logic                         o_disp_ok;
  logic [rob_pkg::CMT_ID_W-1:0] o_new_cmt_id;
  logic                         o_issue_alu_ready;
  logic                         o_issue_br_ready;
  rob_pkg::commit_t             o_commit;

  rob_pkg::commit_t exp_q [$];  // Expected commits in dispatch order
  rob_pkg::commit_t mon_exp;
  logic [3:0]       next_id;  // Id the next dispatch should receive
  string            cur_test;
  int               errors;
  int               errors_at_start;
  int               tests_run;

  rob_subsys_top #(.ALU_LATENCY(1), .BR_LATENCY(2)) u_dut (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_disp_valid     (i_disp_valid),
    .i_disp_grp       (i_disp_grp),
    .o_disp_ok        (o_disp_ok),
    .o_new_cmt_id     (o_new_cmt_id),
    .i_issue_alu      (i_issue_alu),
    .i_issue_br       (i_issue_br),
    .o_issue_alu_ready(o_issue_alu_ready),
    .o_issue_br_ready (o_issue_br_ready),
    .o_commit         (o_commit)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  task automatic tick;
    @(posedge i_clk);
    #1;
  endtask

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("ERR %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  function automatic rob_pkg::disp_grp_t make_grp(input logic [31:0] pc, input logic [1:0] vmask,
                                                  input logic [5:0] rd0, input logic [5:0] rd1);
    rob_pkg::disp_grp_t g;
    g                  = '0;
    g.pc               = pc;
    g.slot[0].valid    = vmask[0];
    g.slot[0].rd_valid = vmask[0];
    g.slot[0].rd_tag   = rd0;
    g.slot[1].valid    = vmask[1];
    g.slot[1].rd_valid = vmask[1];
    g.slot[1].rd_tag   = rd1;
    return g;
  endfunction

  // Plain in-order retire of every valid slot
  function automatic rob_pkg::commit_t expect_grp(input logic [3:0] id,
                                                  input rob_pkg::disp_grp_t g);
    rob_pkg::commit_t e;
    e        = '0;
    e.commit = 1'b1;
    e.cmt_id = id;
    for (int d = 0; d < 2; d++) begin
      e.grp_id[d]   = g.slot[d].valid;
      e.rd_valid[d] = g.slot[d].valid & g.slot[d].rd_valid;
      e.rd_tag[d]   = g.slot[d].rd_tag;
    end
    return e;
  endfunction

  function automatic rob_pkg::commit_t expect_dead(input logic [3:0] id,
                                                   input rob_pkg::disp_grp_t g);
    rob_pkg::commit_t e;
    e          = expect_grp(id, g);
    e.all_dead = 1'b1;
    e.dead_id  = e.grp_id;
    return e;
  endfunction

  task automatic compare_commit(input rob_pkg::commit_t e);
    check_val("cmt_id", e.cmt_id, o_commit.cmt_id);
    check_val("grp_id", e.grp_id, o_commit.grp_id);
    check_val("all_dead", e.all_dead, o_commit.all_dead);
    check_val("dead_id", e.dead_id, o_commit.dead_id);
    check_val("upd_pc_valid", e.upd_pc_valid, o_commit.upd_pc_valid);
    if (e.upd_pc_valid) check_val("upd_pc_vaddr", e.upd_pc_vaddr, o_commit.upd_pc_vaddr);
    check_val("except_valid", e.except_valid, o_commit.except_valid);
    if (|e.except_valid) begin
      check_val("except_type", e.except_type, o_commit.except_type);
      check_val("epc", e.epc, o_commit.epc);
    end
    check_val("rd_valid", e.rd_valid, o_commit.rd_valid);
    for (int d = 0; d < 2; d++) begin
      if (e.rd_valid[d]) check_val("rd_tag", e.rd_tag[d], o_commit.rd_tag[d]);
    end
  endtask

  // Commit output depends only on registers and settles before the falling edge
  always @(negedge i_clk) begin
    if (i_reset_n && o_commit.commit) begin
      assert (exp_q.size() > 0) else begin
        $display("%s: commit of id %0d arrived with no commit expected", cur_test,
                 o_commit.cmt_id);
        errors++;
      end
      if (exp_q.size() > 0) begin
        mon_exp = exp_q.pop_front();
        compare_commit(mon_exp);
      end
    end
  end

  task automatic dispatch(input rob_pkg::disp_grp_t g, output logic [3:0] id);
    int n;
    n = 0;
    while (!o_disp_ok && n < TIMEOUT) begin
      tick;
      n++;
    end
    assert (o_disp_ok) else begin
      $display("%s: timed out waiting for dispatch credit", cur_test);
      errors++;
    end
    check_val("o_new_cmt_id", next_id, o_new_cmt_id);
    id           = next_id;
    next_id      = next_id + 1'b1;
    i_disp_valid = 1'b1;
    i_disp_grp   = g;
    tick;
    i_disp_valid = 1'b0;
  endtask

  task automatic issue_op(input bit to_br, input logic [3:0] id, input bit slot,
                          input bit exc = 1'b0, input rob_pkg::except_t code = rob_pkg::NONE,
                          input bit taken = 1'b0, input logic [31:0] tgt = 32'h0);
    rob_pkg::exec_op_t op;
    int                n;
    op              = '0;
    op.valid        = 1'b1;
    op.cmt_id       = id;
    op.slot         = slot;
    op.except_valid = exc;
    op.except_type  = code;
    op.br_taken     = taken;
    op.br_target    = tgt;
    n = 0;
    while (!(to_br ? o_issue_br_ready : o_issue_alu_ready) && n < TIMEOUT) begin
      tick;
      n++;
    end
    assert (n < TIMEOUT) else begin
      $display("%s: timed out waiting for a pipe to accept an operation", cur_test);
      errors++;
    end
    if (to_br) i_issue_br = op;
    else       i_issue_alu = op;
    tick;
    if (to_br) i_issue_br = '0;
    else       i_issue_alu = '0;
  endtask

  task automatic wait_drain(input int left);
    int n;
    n = 0;
    while (exp_q.size() > left && n < TIMEOUT) begin
      tick;
      n++;
    end
    assert (exp_q.size() <= left) else begin
      $display("%s: timed out with %0d expected commits never seen", cur_test, exp_q.size());
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test        = name;
    errors_at_start = errors;
  endtask

  task automatic end_test;
    wait_drain(0);
    repeat (3) tick;  // Room for a stray commit to show up
    tests_run++;
    $display("%s finished, %0d errors", cur_test, errors - errors_at_start);
  endtask

  task automatic test_in_order_commit;
    rob_pkg::disp_grp_t g [4];
    logic [3:0]         id [4];
    start_test("test_in_order_commit");
    for (int k = 0; k < 4; k++) begin
      g[k] = make_grp(32'h100 + 32'(k * 8), 2'b11, 6'(2 * k), 6'(2 * k + 1));
      dispatch(g[k], id[k]);
      exp_q.push_back(expect_grp(id[k], g[k]));
    end
    for (int k = 3; k >= 0; k--) begin  // Youngest first
      issue_op(1'b1, id[k], 1'b1);
      issue_op(1'b0, id[k], 1'b0);
    end
    end_test();
  endtask

  task automatic test_branch_flush;
    rob_pkg::disp_grp_t ga, gb, gc;
    logic [3:0]         ida, idb, idc;
    rob_pkg::commit_t   e;
    start_test("test_branch_flush");
    ga = make_grp(32'h1000, 2'b11, 6'd10, 6'd11);
    gb = make_grp(32'h1008, 2'b11, 6'd12, 6'd13);
    gc = make_grp(32'h1010, 2'b01, 6'd14, 6'd0);
    dispatch(ga, ida);
    dispatch(gb, idb);
    dispatch(gc, idc);
    e              = expect_grp(ida, ga);
    e.upd_pc_valid = 1'b1;
    e.upd_pc_vaddr = 32'h2000;
    e.dead_id      = 2'b10;
    exp_q.push_back(e);
    exp_q.push_back(expect_dead(idb, gb));
    exp_q.push_back(expect_dead(idc, gc));
    issue_op(1'b0, ida, 1'b1);
    issue_op(1'b1, ida, 1'b0, 1'b0, rob_pkg::NONE, 1'b1, 32'h2000);
    end_test();
  endtask

  task automatic test_exception;
    rob_pkg::disp_grp_t g;
    logic [3:0]         id;
    rob_pkg::commit_t   e;
    start_test("test_exception");
    g = make_grp(32'h3000, 2'b11, 6'd20, 6'd21);
    dispatch(g, id);
    e                 = expect_grp(id, g);
    e.upd_pc_valid    = 1'b1;
    e.upd_pc_vaddr    = TRAP_VADDR;
    e.except_valid    = 2'b10;
    e.except_type     = rob_pkg::ECALL;
    e.epc             = 32'h3000 + 32'd4;
    exp_q.push_back(e);
    issue_op(1'b0, id, 1'b1, 1'b1, rob_pkg::ECALL);
    issue_op(1'b1, id, 1'b0);
    end_test();
  endtask

  task automatic test_credit_full;
    rob_pkg::disp_grp_t g;
    logic [3:0]         id [8];
    start_test("test_credit_full");
    for (int k = 0; k < 8; k++) begin
      g = make_grp(32'h4000 + 32'(k * 8), 2'b01, 6'(30 + k), 6'd0);
      dispatch(g, id[k]);
      exp_q.push_back(expect_grp(id[k], g));
    end
    check_val("o_disp_ok when full", 1'b0, o_disp_ok);
    issue_op(1'b0, id[0], 1'b0);
    wait_drain(7);
    check_val("o_disp_ok after commit", 1'b1, o_disp_ok);
    for (int k = 1; k < 8; k++) issue_op(k[0], id[k], 1'b0);
    end_test();
  endtask

  task automatic test_arbiter_contention;
    rob_pkg::disp_grp_t g;
    logic [3:0]         id;
    rob_pkg::exec_op_t  op;
    rob_pkg::exec_op_t  alu_q [$];
    rob_pkg::exec_op_t  br_q [$];
    int                 pick;
    int                 n;
    int                 n_stall;
    start_test("test_arbiter_contention");
    n_stall = 0;
    for (int k = 0; k < 6; k++) begin
      g = make_grp(32'h5000 + 32'(k * 8), 2'b11, 6'($urandom), 6'($urandom));
      dispatch(g, id);
      exp_q.push_back(expect_grp(id, g));
      for (int s = 0; s < 2; s++) begin
        op        = '0;
        op.valid  = 1'b1;
        op.cmt_id = id;
        op.slot   = s[0];
        pick = (2 * k + s < 4) ? s : int'($urandom % 2);  // First two groups split across pipes
        if (pick == 0) alu_q.push_back(op);
        else           br_q.push_back(op);
      end
    end
    n = 0;
    while ((alu_q.size() > 0 || br_q.size() > 0) && n < TIMEOUT) begin
      if (!o_issue_alu_ready || !o_issue_br_ready) begin
        n_stall++;
      end
      i_issue_alu = '0;
      i_issue_br  = '0;
      if (alu_q.size() > 0 && o_issue_alu_ready) begin
        i_issue_alu = alu_q.pop_front();
      end
      if (br_q.size() > 0 && o_issue_br_ready) begin
        i_issue_br = br_q.pop_front();
      end
      tick;
      n++;
    end
    i_issue_alu = '0;
    i_issue_br  = '0;
    assert (n < TIMEOUT) else begin
      $display("%s: timed out issuing operations under back-pressure", cur_test);
      errors++;
    end
    assert (n_stall > 0) else begin
      $display("%s: no issue back-pressure seen while both pipes were reporting", cur_test);
      errors++;
    end
    end_test();
  endtask

  initial begin
    void'($urandom(32'h2b58));
    errors       = 0;
    tests_run    = 0;
    next_id      = '0;
    cur_test     = "reset";
    i_reset_n    = 1'b0;
    i_disp_valid = 1'b0;
    i_disp_grp   = '0;
    i_issue_alu  = '0;
    i_issue_br   = '0;
    repeat (4) @(posedge i_clk);
    #1;
    i_reset_n = 1'b1;
    tick;
    check_val("o_disp_ok after reset", 1'b1, o_disp_ok);
    test_in_order_commit();
    test_branch_flush();
    test_exception();
    test_credit_full();
    test_arbiter_contention();
    $display("tests %0d, errors %0d", tests_run, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: compile.f
rob_pkg.sv
rob_entry.sv
rob_credit_counter.sv
done_arbiter.sv
exec_pipe.sv
rob_commit_sel.sv
rob.sv
rob_subsys_top.sv
tb_rob.sv

// File: run.sh
#!/bin/sh
# Build and run tb_rob with Verilator, verdict taken from the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_rob -f compile.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_rob > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "ALL CHECKS PASSED" "$LOG"; then
  echo "Simulation ended without a verdict"
  exit 1
fi
exit 0
